//--- src/mips_dbg_pkg.sv
`default_nettype none

package mips_dbg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and memory.
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W     = 32;
    // Word address into the program RAM.
    localparam int ADDR_W     = 10;
    localparam int MEM_DEPTH  = 1024;
    // PC and cycle count both go out as 16-bit fields.
    localparam int CYCLE_W    = 16;
    localparam int OPCODE_W   = 6;
    localparam logic [OPCODE_W-1:0] HALT_OPCODE = '0;

    ////////////////////////////////////////////////////////////////////////////
    // UART framing and timing.
    ////////////////////////////////////////////////////////////////////////////
    localparam int BYTE_W        = 8;
    localparam int STOP_BITS     = 2;
    // Ticks per bit, and clocks per tick.
    localparam int OVERSAMPLE    = 16;
    localparam int CLKS_PER_TICK = 4;
    localparam int DIV_W         = $clog2(CLKS_PER_TICK);
    localparam int TICK_CNT_W    = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_W     = $clog2(BYTE_W);

    ////////////////////////////////////////////////////////////////////////////
    // Host protocol.
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [BYTE_W-1:0] CMD_LOAD = 8'h01;
    localparam logic [BYTE_W-1:0] CMD_RUN  = 8'h02;
    localparam logic [BYTE_W-1:0] CMD_STEP = 8'h03;
    localparam logic [BYTE_W-1:0] CMD_DUMP = 8'h04;
    localparam logic [BYTE_W-1:0] ACK_BYTE = 8'hA5;
    localparam int DUMP_BYTES = 8;
    localparam int DUMP_IDX_W = $clog2(DUMP_BYTES);
    // Index of a byte inside a program word.
    localparam int BYTE_IDX_W = $clog2(WORD_W / BYTE_W);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD_LEN,
        ST_LOAD_BYTE,
        ST_LOAD_WR,
        ST_LOAD_DONE,
        ST_RUN_CLR,
        ST_RUN,
        ST_STEP,
        ST_STEP_WAIT,
        ST_ACK,
        ST_SEND,
        ST_SEND_WAIT
    } dbg_state_t;

endpackage

`default_nettype wire

//--- src/mem_port_if.sv
`default_nettype none

interface mem_port_if;
    import mips_dbg_pkg::*;

    // Request, held until granted.
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    // Same-cycle grant.
    logic              gnt;
    // Read word, one cycle after the grant.
    logic [WORD_W-1:0] rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- src/baud_rate_generator.sv
`default_nettype none

module baud_rate_generator (
    input  logic i_clock,
    input  logic i_rst,
    output logic o_tick
);
    import mips_dbg_pkg::*;

    logic [DIV_W-1:0] div_q;
    logic             div_end;

    // Last clock of the tick period.
    assign div_end = (div_q == DIV_W'(CLKS_PER_TICK - 1));

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            div_q  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= div_end;
            div_q  <= div_end ? '0 : div_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic                            i_clock,
    input  logic                            i_rst,
    input  logic                            i_tick,
    input  logic                            i_rx,
    output logic                            o_rx_done,
    output logic [mips_dbg_pkg::BYTE_W-1:0] o_rx_data
);
    import mips_dbg_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state_q;
    logic [1:0]            sync_q;
    logic [TICK_CNT_W-1:0] tick_q;
    logic [BIT_CNT_W-1:0]  bit_q;
    logic                  rx_s;
    logic                  bit_end;

    // Two-flop synchronizer on the line.
    assign rx_s    = sync_q[1];
    // Centre of a bit, 16 ticks after the previous centre.
    assign bit_end = i_tick && (tick_q == TICK_CNT_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            sync_q    <= 2'b11;
            state_q   <= RX_IDLE;
            tick_q    <= '0;
            bit_q     <= '0;
            o_rx_done <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], i_rx};
            o_rx_done <= 1'b0;
            // Tick counter wraps at 16 by width.
            if (i_tick) begin
                tick_q <= tick_q + 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    tick_q <= '0;
                    if (!rx_s) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at mid-bit.
                    if (i_tick && tick_q == TICK_CNT_W'(OVERSAMPLE / 2 - 1)) begin
                        tick_q  <= '0;
                        bit_q   <= '0;
                        state_q <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == BIT_CNT_W'(BYTE_W - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    // A low stop bit drops the frame.
                    if (bit_end) begin
                        o_rx_done <= rx_s;
                        state_q   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge i_clock) begin
        if (state_q == RX_DATA && bit_end) begin
            o_rx_data <= {rx_s, o_rx_data[BYTE_W-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic                            i_clock,
    input  logic                            i_rst,
    input  logic                            i_tick,
    input  logic                            i_tx_start,
    input  logic [mips_dbg_pkg::BYTE_W-1:0] i_tx_data,
    output logic                            o_tx,
    output logic                            o_tx_done
);
    import mips_dbg_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t             state_q;
    logic [TICK_CNT_W-1:0] tick_q;
    logic [BIT_CNT_W-1:0]  bit_q;
    logic [BYTE_W-1:0]     shift_q;
    logic                  bit_end;

    // Last tick of the current bit.
    assign bit_end = i_tick && (tick_q == TICK_CNT_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state_q   <= TX_IDLE;
            tick_q    <= '0;
            bit_q     <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick && state_q != TX_IDLE) begin
                tick_q <= tick_q + 1'b1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (i_tx_start) begin
                        tick_q  <= '0;
                        o_tx    <= 1'b0;
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_q   <= '0;
                        o_tx    <= shift_q[0];
                        state_q <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        o_tx  <= shift_q[1];
                        if (bit_q == BIT_CNT_W'(BYTE_W - 1)) begin
                            bit_q   <= '0;
                            o_tx    <= 1'b1;
                            state_q <= TX_STOP;
                        end
                    end
                end
                default: begin
                    // Bit counter reused to count stop bits.
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == BIT_CNT_W'(STOP_BITS - 1)) begin
                            o_tx_done <= 1'b1;
                            state_q   <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Byte latched on start, shifted LSB first.
    always_ff @(posedge i_clock) begin
        if (state_q == TX_IDLE && i_tx_start) begin
            shift_q <= i_tx_data;
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

//--- src/program_memory.sv
`default_nettype none

module program_memory (
    input logic         i_clock,
    mem_port_if.arbiter mem_port
);
    import mips_dbg_pkg::*;

    logic [WORD_W-1:0] ram_q [MEM_DEPTH];

    // Always ready for the one arbitrated port.
    assign mem_port.gnt = mem_port.req;

    // Read-first port, registered output.
    always_ff @(posedge i_clock) begin
        if (mem_port.gnt) begin
            if (mem_port.we) begin
                ram_q[mem_port.addr] <= mem_port.wdata;
            end
            mem_port.rdata <= ram_q[mem_port.addr];
        end
    end

endmodule

`default_nettype wire

//--- src/prog_mem_arbiter.sv
`default_nettype none

module prog_mem_arbiter (
    input logic           i_clock,
    input logic           i_rst,
    mem_port_if.arbiter   dbg_port,
    mem_port_if.arbiter   fetch_port,
    mem_port_if.requester mem_port
);

    // Owner of last cycle's grant, 1 for the debug port.
    logic dbg_owner_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority, debug port first.
    ////////////////////////////////////////////////////////////////////////////
    assign mem_port.req   = dbg_port.req || fetch_port.req;
    assign mem_port.we    = dbg_port.req ? dbg_port.we    : fetch_port.we;
    assign mem_port.addr  = dbg_port.req ? dbg_port.addr  : fetch_port.addr;
    assign mem_port.wdata = dbg_port.req ? dbg_port.wdata : fetch_port.wdata;

    assign dbg_port.gnt   = dbg_port.req && mem_port.gnt;
    assign fetch_port.gnt = fetch_port.req && !dbg_port.req && mem_port.gnt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            dbg_owner_q <= 1'b0;
        end else if (mem_port.gnt) begin
            dbg_owner_q <= dbg_port.req;
        end
    end

    // Read word back to whoever was granted.
    assign dbg_port.rdata   = dbg_owner_q ? mem_port.rdata : '0;
    assign fetch_port.rdata = dbg_owner_q ? '0 : mem_port.rdata;

endmodule

`default_nettype wire

//--- src/instruction_fetch.sv
`default_nettype none

module instruction_fetch (
    input  logic                             i_clock,
    input  logic                             i_rst,
    input  logic                             i_run_en,
    input  logic                             i_step,
    input  logic                             i_clear,
    mem_port_if.requester                    mem_port,
    output logic                             o_halted,
    output logic [mips_dbg_pkg::ADDR_W-1:0]  o_pc,
    output logic [mips_dbg_pkg::CYCLE_W-1:0] o_cycle_count,
    output logic [mips_dbg_pkg::WORD_W-1:0]  o_instr
);
    import mips_dbg_pkg::*;

    logic step_pend_q;
    // Read granted last cycle, word arrives now.
    logic busy_q;
    logic is_halt;

    assign is_halt = (mem_port.rdata[WORD_W-1 -: OPCODE_W] == HALT_OPCODE);

    // A step fetches even when halted.
    assign mem_port.req   = ((i_run_en && !o_halted) || step_pend_q) && !busy_q && !i_clear;
    assign mem_port.we    = 1'b0;
    assign mem_port.addr  = o_pc;
    assign mem_port.wdata = '0;

    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            o_pc          <= '0;
            o_cycle_count <= '0;
            o_instr       <= '0;
            o_halted      <= 1'b0;
            step_pend_q   <= 1'b0;
            busy_q        <= 1'b0;
        end else begin
            if (i_step) begin
                step_pend_q <= 1'b1;
            end
            if (mem_port.gnt) begin
                busy_q <= 1'b1;
            end
            // Capture cycle.
            if (busy_q) begin
                busy_q        <= 1'b0;
                step_pend_q   <= i_step;
                o_instr       <= mem_port.rdata;
                o_cycle_count <= o_cycle_count + 1'b1;
                // PC stays on the HALT word.
                if (is_halt) begin
                    o_halted <= 1'b1;
                end else begin
                    o_pc <= o_pc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/debug_unit.sv
`default_nettype none

module debug_unit (
    input  logic                             i_clock,
    input  logic                             i_rst,
    input  logic                             i_rx_done,
    input  logic [mips_dbg_pkg::BYTE_W-1:0]  i_rx_data,
    input  logic                             i_tx_done,
    output logic                             o_tx_start,
    output logic [mips_dbg_pkg::BYTE_W-1:0]  o_tx_data,
    mem_port_if.requester                    mem_port,
    input  logic                             i_halted,
    input  logic [mips_dbg_pkg::ADDR_W-1:0]  i_pc,
    input  logic [mips_dbg_pkg::CYCLE_W-1:0] i_cycle_count,
    input  logic [mips_dbg_pkg::WORD_W-1:0]  i_instr,
    output logic                             o_run_en,
    output logic                             o_step,
    output logic                             o_clear
);
    import mips_dbg_pkg::*;

    dbg_state_t                   state_q;
    logic [BYTE_W-1:0]            words_left_q;
    logic [BYTE_IDX_W-1:0]        byte_idx_q;
    logic [ADDR_W-1:0]            addr_q;
    // Load word, or cycle count snapshot during a step.
    logic [WORD_W-1:0]            word_q;
    // Reply bytes, sent from the top.
    logic [DUMP_BYTES*BYTE_W-1:0] dump_q;
    logic [DUMP_IDX_W-1:0]        bytes_left_q;
    logic                         cmd_valid;

    // Commands are only taken when idle.
    assign cmd_valid = (state_q == ST_IDLE) && i_rx_done;

    ////////////////////////////////////////////////////////////////////////////
    // Outputs decoded from state.
    ////////////////////////////////////////////////////////////////////////////
    assign o_tx_start     = (state_q == ST_SEND);
    assign o_tx_data      = dump_q[DUMP_BYTES*BYTE_W-1 -: BYTE_W];
    assign o_clear        = (state_q == ST_LOAD_DONE) || (state_q == ST_RUN_CLR);
    assign o_run_en       = (state_q == ST_RUN);
    assign o_step         = (state_q == ST_STEP);
    assign mem_port.req   = (state_q == ST_LOAD_WR);
    assign mem_port.we    = mem_port.req;
    assign mem_port.addr  = addr_q;
    assign mem_port.wdata = word_q;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state_q      <= ST_IDLE;
            words_left_q <= '0;
            byte_idx_q   <= '0;
            addr_q       <= '0;
            bytes_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Unknown bytes fall through.
                    if (cmd_valid) begin
                        case (i_rx_data)
                            CMD_LOAD: state_q <= ST_LOAD_LEN;
                            CMD_RUN:  state_q <= ST_RUN_CLR;
                            CMD_STEP: state_q <= ST_STEP;
                            CMD_DUMP: begin
                                bytes_left_q <= DUMP_IDX_W'(DUMP_BYTES - 1);
                                state_q      <= ST_SEND;
                            end
                            default: state_q <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD_LEN: begin
                    if (i_rx_done) begin
                        words_left_q <= i_rx_data;
                        addr_q       <= '0;
                        byte_idx_q   <= '0;
                        state_q      <= (i_rx_data == '0) ? ST_LOAD_DONE : ST_LOAD_BYTE;
                    end
                end
                ST_LOAD_BYTE: begin
                    if (i_rx_done) begin
                        byte_idx_q <= byte_idx_q + 1'b1;
                        if (byte_idx_q == '1) begin
                            state_q <= ST_LOAD_WR;
                        end
                    end
                end
                ST_LOAD_WR: begin
                    if (mem_port.gnt) begin
                        addr_q       <= addr_q + 1'b1;
                        words_left_q <= words_left_q - 1'b1;
                        state_q      <= (words_left_q == 8'd1) ? ST_LOAD_DONE : ST_LOAD_BYTE;
                    end
                end
                ST_LOAD_DONE: state_q <= ST_ACK;
                ST_RUN_CLR:   state_q <= ST_RUN;
                ST_RUN: begin
                    if (i_halted) begin
                        state_q <= ST_ACK;
                    end
                end
                ST_STEP: state_q <= ST_STEP_WAIT;
                ST_STEP_WAIT: begin
                    // Count moves once the word is captured.
                    if (i_cycle_count != word_q[CYCLE_W-1:0]) begin
                        state_q <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    bytes_left_q <= '0;
                    state_q      <= ST_SEND;
                end
                ST_SEND: state_q <= ST_SEND_WAIT;
                ST_SEND_WAIT: begin
                    if (i_tx_done) begin
                        bytes_left_q <= bytes_left_q - 1'b1;
                        state_q      <= (bytes_left_q == '0) ? ST_IDLE : ST_SEND;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload path.
    always_ff @(posedge i_clock) begin
        if (state_q == ST_LOAD_BYTE && i_rx_done) begin
            word_q <= {word_q[WORD_W-BYTE_W-1:0], i_rx_data};
        end else if (cmd_valid && i_rx_data == CMD_STEP) begin
            word_q <= WORD_W'(i_cycle_count);
        end
        if (cmd_valid && i_rx_data == CMD_DUMP) begin
            dump_q <= {CYCLE_W'(i_pc), i_cycle_count, i_instr};
        end else if (state_q == ST_ACK) begin
            dump_q <= {ACK_BYTE, {((DUMP_BYTES - 1) * BYTE_W){1'b0}}};
        end else if (state_q == ST_SEND_WAIT && i_tx_done) begin
            dump_q <= dump_q << BYTE_W;
        end
    end

endmodule

`default_nettype wire

//--- src/mips_debug_top.sv
`default_nettype none

module mips_debug_top (
    input  logic i_clock,
    input  logic i_rst,
    input  logic i_uart_rx,
    output logic o_uart_tx
);
    import mips_dbg_pkg::*;

    // UART path.
    logic               tick;
    logic               rx_done;
    logic [BYTE_W-1:0]  rx_data;
    logic               tx_start;
    logic [BYTE_W-1:0]  tx_data;
    logic               tx_done;
    // Debug to fetch control and status.
    logic               run_en;
    logic               step;
    logic               clear;
    logic               halted;
    logic [ADDR_W-1:0]  pc;
    logic [CYCLE_W-1:0] cycle_count;
    logic [WORD_W-1:0]  instr;

    mem_port_if dbg_bus ();
    mem_port_if fetch_bus ();
    mem_port_if mem_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Host link.
    ////////////////////////////////////////////////////////////////////////////
    baud_rate_generator baud_rate_generator_i (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .o_tick  (tick)
    );

    uart_rx uart_rx_i (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_tick    (tick),
        .i_rx      (i_uart_rx),
        .o_rx_done (rx_done),
        .o_rx_data (rx_data)
    );

    uart_tx uart_tx_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx       (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Debug unit and fetch stage, sharing program memory.
    ////////////////////////////////////////////////////////////////////////////
    debug_unit debug_unit_i (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_rx_done     (rx_done),
        .i_rx_data     (rx_data),
        .i_tx_done     (tx_done),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .mem_port      (dbg_bus.requester),
        .i_halted      (halted),
        .i_pc          (pc),
        .i_cycle_count (cycle_count),
        .i_instr       (instr),
        .o_run_en      (run_en),
        .o_step        (step),
        .o_clear       (clear)
    );

    instruction_fetch instruction_fetch_i (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_run_en      (run_en),
        .i_step        (step),
        .i_clear       (clear),
        .mem_port      (fetch_bus.requester),
        .o_halted      (halted),
        .o_pc          (pc),
        .o_cycle_count (cycle_count),
        .o_instr       (instr)
    );

    prog_mem_arbiter prog_mem_arbiter_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .dbg_port   (dbg_bus.arbiter),
        .fetch_port (fetch_bus.arbiter),
        .mem_port   (mem_bus.requester)
    );

    program_memory program_memory_i (
        .i_clock  (i_clock),
        .mem_port (mem_bus.arbiter)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic o_clock
);

    // Period of 8, starting low.
    initial begin
        o_clock = 1'b0;
    end

    always begin
        #4 o_clock = ~o_clock;
    end

endmodule

`default_nettype wire

//--- tb/tb_mips_debug_top.sv
`default_nettype none

module tb_mips_debug_top;
    import mips_dbg_pkg::*;

    typedef struct {
        string name;
        int    len;
        int    halt_idx;
        int    steps;
    } test_row_t;

    logic              clock;
    logic              rst;
    logic              uart_rx;
    logic              uart_tx;
    // Bit and frame length in clocks.
    int                bit_clks;
    int                frame_clks;
    logic [31:0]       lcg_state;
    logic [BYTE_W-1:0] cmd_q [$];
    logic [BYTE_W-1:0] reply_q [$];
    test_row_t         rows [4];
    int                test_errs;
    int                total_errs;
    int                passed;
    int                failed;
    // Reference model of memory and fetch state.
    logic [WORD_W-1:0]  mem_model [MEM_DEPTH];
    logic [CYCLE_W-1:0] m_pc;
    logic [CYCLE_W-1:0] m_count;
    logic [WORD_W-1:0]  m_instr;
    logic               m_halted;

    tb_clock_gen tb_clock_gen_i (
        .o_clock (clock)
    );

    mips_debug_top mips_debug_top_i (
        .i_clock   (clock),
        .i_rst     (rst),
        .i_uart_rx (uart_rx),
        .o_uart_tx (uart_tx)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model.
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task model_clear();
        m_pc     = '0;
        m_count  = '0;
        m_instr  = '0;
        m_halted = 1'b0;
    endtask

    // One captured instruction with PC parked on a HALT word.
    task model_fetch();
        m_instr = mem_model[m_pc[ADDR_W-1:0]];
        m_count = m_count + 1'b1;
        if (m_instr[WORD_W-1 -: OPCODE_W] == HALT_OPCODE) begin
            m_halted = 1'b1;
        end else begin
            m_pc = m_pc + 1'b1;
        end
    endtask

    task model_run();
        int g;
        model_clear();
        for (g = 0; g < MEM_DEPTH && !m_halted; g++) begin
            model_fetch();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // UART byte driver and monitor.
    ////////////////////////////////////////////////////////////////////////////
    task abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Start bit, 8 data bits LSB first, 2 stop bits.
    task send_byte(input logic [BYTE_W-1:0] data);
        logic [BYTE_W+STOP_BITS:0] frame;
        int i;
        frame = {{STOP_BITS{1'b1}}, data, 1'b0};
        for (i = 0; i < BYTE_W + STOP_BITS + 1; i++) begin
            @(negedge clock);
            uart_rx = frame[i];
            repeat (bit_clks - 1) @(negedge clock);
        end
    endtask

    // Samples at bit centres and returns mid last stop bit.
    task recv_byte(output logic [BYTE_W-1:0] data, output bit got, input int limit);
        int n;
        int i;
        got  = 1'b0;
        data = '0;
        n    = 0;
        while (uart_tx !== 1'b0 && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (uart_tx === 1'b0) begin
            repeat (bit_clks / 2) @(negedge clock);
            for (i = 0; i < BYTE_W; i++) begin
                repeat (bit_clks) @(negedge clock);
                data[i] = uart_tx;
            end
            got = 1'b1;
            for (i = 0; i < STOP_BITS; i++) begin
                repeat (bit_clks) @(negedge clock);
                got = got && (uart_tx === 1'b1);
            end
        end
    endtask

    // Sends cmd_q while collecting the reply into reply_q.
    task transact(input int n_reply);
        int                si;
        int                ri;
        int                limit;
        logic [BYTE_W-1:0] rx_byte;
        bit                got;
        limit = (cmd_q.size() + 4) * frame_clks;
        reply_q.delete();
        fork
            begin
                for (si = 0; si < cmd_q.size(); si++) begin
                    send_byte(cmd_q[si]);
                end
            end
            begin
                for (ri = 0; ri < n_reply; ri++) begin
                    recv_byte(rx_byte, got, limit);
                    if (!got) begin
                        abort_run("Timed out waiting for a valid reply byte from the DUT.");
                    end
                    reply_q.push_back(rx_byte);
                end
            end
        join
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Commands and checks.
    ////////////////////////////////////////////////////////////////////////////
    task check_ack(input string name);
        if (reply_q[0] !== ACK_BYTE) begin
            $display("[ERROR] %s: expected %h, actual %h", name, ACK_BYTE, reply_q[0]);
            test_errs++;
        end
    endtask

    task command_ack(input string name, input logic [BYTE_W-1:0] cmd);
        cmd_q.delete();
        cmd_q.push_back(cmd);
        transact(1);
        check_ack(name);
    endtask

    // Dump holds PC, count and instruction MSB first.
    task check_dump(input string name);
        logic [DUMP_BYTES*BYTE_W-1:0] act;
        logic [DUMP_BYTES*BYTE_W-1:0] exp;
        int i;
        cmd_q.delete();
        cmd_q.push_back(CMD_DUMP);
        transact(DUMP_BYTES);
        act = '0;
        for (i = 0; i < DUMP_BYTES; i++) begin
            act = {act[(DUMP_BYTES-1)*BYTE_W-1:0], reply_q[i]};
        end
        exp = {m_pc, m_count, m_instr};
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    // Random words where only the HALT index has a zero opcode.
    task load_program(input string name, input int len, input int halt_idx);
        logic [31:0]       r1;
        logic [31:0]       r2;
        logic [WORD_W-1:0] w;
        int                i;
        int                b;
        cmd_q.delete();
        cmd_q.push_back(CMD_LOAD);
        cmd_q.push_back(len[BYTE_W-1:0]);
        for (i = 0; i < len; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            w  = {r1[31:16], r2[31:16]};
            if (i == halt_idx) begin
                w[WORD_W-1 -: OPCODE_W] = HALT_OPCODE;
            end else if (w[WORD_W-1 -: OPCODE_W] == HALT_OPCODE) begin
                w[WORD_W-OPCODE_W] = 1'b1;
            end
            mem_model[i] = w;
            for (b = WORD_W / BYTE_W - 1; b >= 0; b--) begin
                cmd_q.push_back(w[b*BYTE_W +: BYTE_W]);
            end
        end
        model_clear();
        transact(1);
        check_ack(name);
    endtask

    task run_row(input test_row_t row);
        logic [BYTE_W-1:0] rx_byte;
        bit                got;
        int                s;
        load_program({row.name, " load"}, row.len, row.halt_idx);
        check_dump({row.name, " dump after load"});
        for (s = 0; s < row.steps; s++) begin
            model_fetch();
            command_ack({row.name, " step"}, CMD_STEP);
        end
        check_dump({row.name, " dump after steps"});
        model_run();
        command_ack({row.name, " run"}, CMD_RUN);
        check_dump({row.name, " dump after run"});
        // Unknown command byte gets no reply within two byte times.
        fork
            send_byte(8'h7E);
            recv_byte(rx_byte, got, 3 * frame_clks);
        join
        if (got) begin
            $display("%s: DUT replied %h to an unknown command byte", row.name, rx_byte);
            test_errs++;
        end
        check_dump({row.name, " dump after unknown byte"});
        // Step past HALT refetches the HALT word.
        model_fetch();
        command_ack({row.name, " step after halt"}, CMD_STEP);
        check_dump({row.name, " dump after halt step"});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst        = 1'b1;
        uart_rx    = 1'b1;
        lcg_state  = 32'd56901;
        total_errs = 0;
        passed     = 0;
        failed     = 0;
        bit_clks   = OVERSAMPLE * CLKS_PER_TICK;
        frame_clks = (1 + BYTE_W + STOP_BITS) * bit_clks;
        model_clear();
        // Name, length, HALT index, steps.
        rows[0] = '{"short_prog", 6, 4, 2};
        rows[1] = '{"long_prog", 24, 20, 5};
        rows[2] = '{"reload_short", 5, 2, 1};
        rows[3] = '{"halt_first", 3, 0, 0};
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        repeat (bit_clks) @(negedge clock);
        for (int t = 0; t < 4; t++) begin
            test_errs = 0;
            run_row(rows[t]);
            total_errs += test_errs;
            if (test_errs == 0) begin
                passed++;
                $display("test %-14s passed", rows[t].name);
            end else begin
                failed++;
                $display("test %-14s failed with %0d errors", rows[t].name, test_errs);
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, total_errs);
        if (total_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/mips_dbg_pkg.sv
src/mem_port_if.sv
src/baud_rate_generator.sv
src/uart_rx.sv
src/uart_tx.sv
src/program_memory.sv
src/prog_mem_arbiter.sv
src/instruction_fetch.sv
src/debug_unit.sv
src/mips_debug_top.sv
tb/tb_clock_gen.sv
tb/tb_mips_debug_top.sv

//--- Bender.yml
package:
  name: mips_debug

sources:
  - src/mips_dbg_pkg.sv
  - src/mem_port_if.sv
  - src/baud_rate_generator.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/program_memory.sv
  - src/prog_mem_arbiter.sv
  - src/instruction_fetch.sv
  - src/debug_unit.sv
  - src/mips_debug_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_mips_debug_top.sv
